// File: issue_stage.f
+incdir+include
verilog/issue_pkg.sv
verilog/issue_queue.sv
verilog/inst_decode.sv
verilog/hazard_check.sv
verilog/pipe_steer.sv
verilog/issue_select.sv
verilog/issue_stage.sv
test/tb_clock.sv
test/issue_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f issue_stage.f --top-module issue_stage_tb -o issue_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/issue_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: test/issue_stage_tb.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module issue_stage_tb;

  localparam int max_cycles = 1000;

  logic                     clk;
  logic                     reset;
  logic                     flush;
  logic                     push0;
  logic                     push1;
  issue_pkg::issue_entry_t  push_data0;
  issue_pkg::issue_entry_t  push_data1;
  issue_pkg::pending_load_t pending_load;
  logic [3:0]               free;
  issue_pkg::lane_t         lane0;
  issue_pkg::lane_t         lane1;

  // reference model state.
  issue_pkg::issue_entry_t  model_q[$];
  issue_pkg::lane_t         exp_lane0;
  issue_pkg::lane_t         exp_lane1;
  logic                     exp_older1;
  logic [3:0]               exp_free;
  issue_pkg::pending_load_t last_pl;
  logic                     flush_d;
  logic                     dual_arm;
  logic                     dual_d1;
  logic                     dual_d2;
  logic [`ID_WIDTH-1:0]     dual_id;

  issue_pkg::decoded_t      lane0_dec;
  issue_pkg::decoded_t      lane1_dec;
  issue_pkg::decoded_t      older_dec;
  issue_pkg::decoded_t      younger_dec;
  logic                     pair_raw;
  logic                     pair_same;
  logic                     lane_load_hit;

  logic [31:0]              lcg_state;
  logic [`ID_WIDTH-1:0]     next_id;
  int                       cycles;
  int                       error_count;

  tb_clock clock_i (
    .clk  (clk),
    .reset(reset)
  );

  issue_stage dut_i (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .push0       (push0),
    .push1       (push1),
    .push_data0  (push_data0),
    .push_data1  (push_data1),
    .pending_load(pending_load),
    .free        (free),
    .lane0       (lane0),
    .lane1       (lane1)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] make_inst(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
    return {op, rs, rt, rd, 11'b0};
  endfunction

  // register use and lane class straight from the opcode table.
  function automatic issue_pkg::decoded_t decode_inst(input logic [31:0] inst);
    issue_pkg::decoded_t d;
    logic [5:0]          op;
    op = inst[31:26];
    d = '0;
    if (op == `OP_JR) begin
      d.src0 = inst[25:21];
      d.use_src0 = 1'b1;
    end else if (op != `OP_NOP && op[5:4] == 2'b00) begin
      d.src0 = inst[25:21];
      d.src1 = inst[20:16];
      d.dest = inst[15:11];
      d.use_src0 = 1'b1;
      d.use_src1 = 1'b1;
      d.use_dest = 1'b1;
    end else if (op[5:4] == 2'b01 || op == `OP_LW) begin
      d.src0 = inst[25:21];
      d.dest = inst[20:16];
      d.use_src0 = 1'b1;
      d.use_dest = 1'b1;
    end else if (op == `OP_SW) begin
      d.src0 = inst[25:21];
      d.src1 = inst[20:16];
      d.use_src0 = 1'b1;
      d.use_src1 = 1'b1;
    end
    if (op == `OP_CMP || op == `OP_TEST || op == `OP_CMPI || op == `OP_TESTI ||
        op[5:4] == 2'b11) begin
      d.pipe = issue_pkg::PIPE_BRANCH;
    end else if (op[5:4] == 2'b10) begin
      d.pipe = issue_pkg::PIPE_MEMORY;
    end else begin
      d.pipe = issue_pkg::PIPE_ANY;
    end
    return d;
  endfunction

  function automatic logic reads_reg(input issue_pkg::decoded_t d, input logic [4:0] r);
    return (d.use_src0 && d.src0 == r) || (d.use_src1 && d.src1 == r);
  endfunction

  function automatic logic same_special(input issue_pkg::decoded_t a,
                                        input issue_pkg::decoded_t b);
    return a.pipe == b.pipe && a.pipe != issue_pkg::PIPE_ANY;
  endfunction

  task automatic report_mismatch(input string name, input logic [103:0] expected,
                                 input logic [103:0] actual);
    error_count++;
    $display("TESTS FAILED");
    $display("[ERROR] %s expected %h actual %h", name, expected, actual);
    $fatal(1, "check %s failed", name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : model_step
    issue_pkg::decoded_t d0;
    issue_pkg::decoded_t d1;
    issue_pkg::lane_t    l0;
    issue_pkg::lane_t    l1;
    logic                blk;
    logic                iss0;
    logic                iss1;
    logic                swp;
    l0 = '0;
    l1 = '0;
    swp = 1'b0;
    if (reset || flush) begin
      model_q.delete(); // same-cycle pushes are lost.
    end else begin
      d0 = (model_q.size() > 0) ? decode_inst(model_q[0].instruction) : '0;
      d1 = (model_q.size() > 1) ? decode_inst(model_q[1].instruction) : '0;
      blk = pending_load.valid &&
            (reads_reg(d0, pending_load.dest) || reads_reg(d1, pending_load.dest));
      iss0 = model_q.size() > 0 && !blk;
      iss1 = iss0 && model_q.size() > 1 && !(d0.use_dest && reads_reg(d1, d0.dest)) &&
             !same_special(d0, d1);
      if (iss1) begin
        swp = d1.pipe == issue_pkg::PIPE_BRANCH || d0.pipe == issue_pkg::PIPE_MEMORY;
        l0 = {1'b1, swp ? model_q[1] : model_q[0]};
        l1 = {1'b1, swp ? model_q[0] : model_q[1]};
        void'(model_q.pop_front());
        void'(model_q.pop_front());
      end else if (iss0) begin
        if (d0.pipe == issue_pkg::PIPE_MEMORY) l1 = {1'b1, model_q[0]};
        else l0 = {1'b1, model_q[0]};
        void'(model_q.pop_front());
      end
      if (push0) model_q.push_back(push_data0);
      if (push1) model_q.push_back(push_data1);
    end
    exp_lane0  <= l0;
    exp_lane1  <= l1;
    exp_older1 <= swp;
    exp_free   <= 4'(8 - model_q.size());
    last_pl    <= pending_load;
    flush_d    <= flush && !reset;
    dual_d1    <= dual_arm;
    dual_d2    <= dual_d1;
  end

  always_comb begin
    lane0_dec = decode_inst(lane0.entry.instruction);
    lane1_dec = decode_inst(lane1.entry.instruction);
    older_dec = exp_older1 ? lane1_dec : lane0_dec;
    younger_dec = exp_older1 ? lane0_dec : lane1_dec;
    pair_raw = older_dec.use_dest && reads_reg(younger_dec, older_dec.dest);
    pair_same = same_special(lane0_dec, lane1_dec);
    lane_load_hit = last_pl.valid &&
                    ((lane0.valid && reads_reg(lane0_dec, last_pl.dest)) ||
                     (lane1.valid && reads_reg(lane1_dec, last_pl.dest)));
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_lane0_order: assert property (@(posedge clk) disable iff (reset)
    lane0.valid == exp_lane0.valid && (!lane0.valid || lane0.entry == exp_lane0.entry))
    else report_mismatch("program_order_lane0", exp_lane0, lane0);

  a_lane1_order: assert property (@(posedge clk) disable iff (reset)
    lane1.valid == exp_lane1.valid && (!lane1.valid || lane1.entry == exp_lane1.entry))
    else report_mismatch("program_order_lane1", exp_lane1, lane1);

  a_lane_classes: assert property (@(posedge clk) disable iff (reset)
    (lane0.valid && lane1.valid) |->
      (lane1_dec.pipe != issue_pkg::PIPE_BRANCH && lane0_dec.pipe != issue_pkg::PIPE_MEMORY))
    else report_mismatch("lane_classes", {2'd0, 2'd0}, {lane0_dec.pipe, lane1_dec.pipe});

  a_single_memory: assert property (@(posedge clk) disable iff (reset)
    (lane0.valid && !lane1.valid) |-> lane0_dec.pipe != issue_pkg::PIPE_MEMORY)
    else report_mismatch("single_memory_lane", issue_pkg::PIPE_ANY, lane0_dec.pipe);

  a_pair_hazard: assert property (@(posedge clk) disable iff (reset)
    (lane0.valid && lane1.valid) |-> !(pair_raw || pair_same))
    else report_mismatch("pair_hazard", 2'b00, {pair_raw, pair_same});

  a_load_use: assert property (@(posedge clk) disable iff (reset)
    !lane_load_hit)
    else report_mismatch("load_use", 1'b0, lane_load_hit);

  a_dual_issue: assert property (@(posedge clk) disable iff (reset)
    dual_d2 |-> (lane0.valid && lane1.valid && lane0.entry.id == dual_id &&
                 lane1.entry.id == dual_id + 1'b1))
    else report_mismatch("dual_issue", {dual_id, dual_id + 1'b1},
                         {lane0.entry.id, lane1.entry.id});

  a_flush_clear: assert property (@(posedge clk) disable iff (reset)
    flush_d |-> (!lane0.valid && !lane1.valid && free == 4'd8))
    else report_mismatch("flush_clear", {2'b00, 4'd8}, {lane0.valid, lane1.valid, free});

  a_free_count: assert property (@(posedge clk) disable iff (reset)
    free == exp_free)
    else report_mismatch("free_count", exp_free, free);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("TESTS FAILED");
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic build_entry(input logic [31:0] inst, output issue_pkg::issue_entry_t e);
    logic [31:0] taken_bits;
    e.instruction = inst;
    e.pc = next_rand();
    e.id = next_id;
    taken_bits = next_rand();
    e.branch_taken = taken_bits[31];
    e.branch_target = next_rand();
    next_id = next_id + 1'b1;
  endtask

  // one cycle of inputs, pushes trimmed to the free count.
  task automatic drive_cycle(input int n, input logic [31:0] i0, input logic [31:0] i1,
                             input issue_pkg::pending_load_t pl, input logic fl);
    int cnt;
    @(posedge clk);
    #1;
    cnt = (n > int'(free)) ? int'(free) : n;
    dual_arm = 1'b0;
    push0 = cnt > 0;
    push1 = cnt > 1;
    if (cnt > 0) build_entry(i0, push_data0);
    if (cnt > 1) build_entry(i1, push_data1);
    pending_load = pl;
    flush = fl;
  endtask

  task automatic drain();
    drive_cycle(0, '0, '0, '0, 1'b0);
    while (free != 4'd8) drive_cycle(0, '0, '0, '0, 1'b0);
    drive_cycle(0, '0, '0, '0, 1'b0);
  endtask

  function automatic logic [31:0] random_inst();
    logic [5:0] ops [8];
    ops = '{`OP_NOP, `OP_CMP, `OP_TEST, `OP_JR, `OP_CMPI, `OP_TESTI, `OP_LW, `OP_SW};
    return make_inst(ops[next_rand() % 8], 5'(next_rand() % 4), 5'(next_rand() % 4),
                     5'(next_rand() % 4));
  endfunction

  initial begin
    issue_pkg::pending_load_t pl;
    lcg_state = 32'ha3ad;
    next_id = '0;
    cycles = 0;
    error_count = 0;
    flush = 1'b0;
    push0 = 1'b0;
    push1 = 1'b0;
    push_data0 = '0;
    push_data1 = '0;
    pending_load = '0;
    dual_arm = 1'b0;
    dual_id = '0;
    @(negedge reset);

    // directed pairs, queue empty before each.
    dual_id = next_id;
    drive_cycle(2, make_inst(6'h01, 5'd1, 5'd2, 5'd5), make_inst(6'h01, 5'd3, 5'd4, 5'd6),
                '0, 1'b0);
    dual_arm = 1'b1;
    drain();
    drive_cycle(2, make_inst(6'h01, 5'd1, 5'd2, 5'd3), make_inst(6'h01, 5'd3, 5'd4, 5'd6),
                '0, 1'b0); // raw between slots.
    drain();
    drive_cycle(2, make_inst(`OP_LW, 5'd1, 5'd2, 5'd0), make_inst(`OP_SW, 5'd3, 5'd4, 5'd0),
                '0, 1'b0);
    drain();
    drive_cycle(2, make_inst(`OP_LW, 5'd1, 5'd2, 5'd0), make_inst(`OP_CMP, 5'd3, 5'd4, 5'd5),
                '0, 1'b0);
    drain();
    pl = '{valid: 1'b1, dest: 5'd7};
    drive_cycle(2, make_inst(`OP_JR, 5'd7, 5'd0, 5'd0), make_inst(6'h01, 5'd1, 5'd2, 5'd3),
                pl, 1'b0);
    drive_cycle(0, '0, '0, pl, 1'b0);
    drive_cycle(0, '0, '0, pl, 1'b1);
    drain();

    // random traffic.
    repeat (400) begin
      pl.valid = (next_rand() % 4) == 0;
      pl.dest = 5'(next_rand() % 4);
      drive_cycle(int'(next_rand() % 3), random_inst(), random_inst(), pl,
                  (next_rand() % 40) == 0);
    end

    drain();
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "%0d checks failed", error_count);
    end
    $finish;
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// File: verilog/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     push0,
  input  logic                     push1,
  input  issue_pkg::issue_entry_t  push_data0,
  input  issue_pkg::issue_entry_t  push_data1,
  input  issue_pkg::pending_load_t pending_load,
  output logic [3:0]               free,
  output issue_pkg::lane_t         lane0,
  output issue_pkg::lane_t         lane1
);

  issue_pkg::issue_entry_t head0;
  issue_pkg::issue_entry_t head1;
  logic [1:0]              head_valid;
  issue_pkg::decoded_t     dec0;
  issue_pkg::decoded_t     dec1;
  logic                    load_block;
  logic                    raw_block;
  logic                    pair_conflict;
  logic                    swap;
  logic [1:0]              pop_count;

  //////////////////////////////////////////////////////////////////////
  // queue and head decode
  //////////////////////////////////////////////////////////////////////

  issue_queue #(
    .payload_t(issue_pkg::issue_entry_t)
  ) queue_i (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .push0     (push0),
    .push1     (push1),
    .push_data0(push_data0),
    .push_data1(push_data1),
    .pop_count (pop_count),
    .head0     (head0),
    .head1     (head1),
    .head_valid(head_valid),
    .free      (free)
  );

  inst_decode dec0_i (
    .instruction(head0.instruction),
    .dec        (dec0)
  );

  inst_decode dec1_i (
    .instruction(head1.instruction),
    .dec        (dec1)
  );

  //////////////////////////////////////////////////////////////////////
  // checks and selection
  //////////////////////////////////////////////////////////////////////

  hazard_check hazard_i (
    .dec0        (dec0),
    .dec1        (dec1),
    .pending_load(pending_load),
    .load_block  (load_block),
    .raw_block   (raw_block)
  );

  pipe_steer steer_i (
    .dec0         (dec0),
    .dec1         (dec1),
    .pair_conflict(pair_conflict),
    .swap         (swap)
  );

  issue_select select_i (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .head0        (head0),
    .head1        (head1),
    .head_valid   (head_valid),
    .dec0         (dec0),
    .dec1         (dec1),
    .load_block   (load_block),
    .raw_block    (raw_block),
    .pair_conflict(pair_conflict),
    .swap         (swap),
    .pop_count    (pop_count),
    .lane0        (lane0),
    .lane1        (lane1)
  );

endmodule

// File: verilog/issue_select.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module issue_select (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  issue_pkg::issue_entry_t head0,
  input  issue_pkg::issue_entry_t head1,
  input  logic [1:0]              head_valid,
  input  issue_pkg::decoded_t     dec0,
  input  issue_pkg::decoded_t     dec1,
  input  logic                    load_block,
  input  logic                    raw_block,
  input  logic                    pair_conflict,
  input  logic                    swap,
  output logic [1:0]              pop_count,
  output issue_pkg::lane_t        lane0,
  output issue_pkg::lane_t        lane1
);

  logic             issue0;
  logic             issue1;
  issue_pkg::lane_t lane0_next;
  issue_pkg::lane_t lane1_next;

  assign issue0 = head_valid[0] && !load_block;
  assign issue1 = issue0 && head_valid[1] && !raw_block && !pair_conflict;

  assign pop_count = issue1 ? 2'd2 : (issue0 ? 2'd1 : 2'd0);

  //////////////////////////////////////////////////////////////////////
  // lane routing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    lane0_next.valid = 1'b0;
    lane1_next.valid = 1'b0;
    lane0_next.entry = head0;
    lane1_next.entry = head1;

    if (issue1) begin
      lane0_next.valid = 1'b1;
      lane1_next.valid = 1'b1;
      lane0_next.entry = swap ? head1 : head0;
      lane1_next.entry = swap ? head0 : head1;
    end else if (issue0) begin
      if (dec0.pipe == issue_pkg::PIPE_MEMORY) begin // single load or store.
        lane1_next.valid = 1'b1;
        lane1_next.entry = head0;
      end else begin
        lane0_next.valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    lane0.entry <= lane0_next.entry;
    lane1.entry <= lane1_next.entry;
    if (reset || flush) begin
      lane0.valid <= 1'b0;
      lane1.valid <= 1'b0;
    end else begin
      lane0.valid <= lane0_next.valid;
      lane1.valid <= lane1_next.valid;
    end
  end

  // a memory op on lane 0 next to a live lane 1 means the steer was wrong.
  a_lane0_no_mem: assert property (@(posedge clk) disable iff (reset)
    (lane0.valid && lane1.valid) |-> lane0.entry.instruction[`OPCODE_MSB -: 2] != 2'b10)
    else $error("memory instruction id %0d on lane 0 beside lane 1", lane0.entry.id);

endmodule

// File: verilog/pipe_steer.sv
`timescale 1ns/1ps

module pipe_steer (
  input  issue_pkg::decoded_t dec0,
  input  issue_pkg::decoded_t dec1,
  output logic                pair_conflict,
  output logic                swap
);

  always_comb begin
    case ({dec0.pipe, dec1.pipe})
      {issue_pkg::PIPE_BRANCH, issue_pkg::PIPE_BRANCH}: begin // one branch lane.
        pair_conflict = 1'b1;
        swap          = 1'b0;
      end
      {issue_pkg::PIPE_MEMORY, issue_pkg::PIPE_MEMORY}: begin // one memory lane.
        pair_conflict = 1'b1;
        swap          = 1'b0;
      end
      {issue_pkg::PIPE_MEMORY, issue_pkg::PIPE_BRANCH}: begin
        pair_conflict = 1'b0;
        swap          = 1'b1;
      end
      {issue_pkg::PIPE_MEMORY, issue_pkg::PIPE_ANY}: begin
        pair_conflict = 1'b0;
        swap          = 1'b1;
      end
      {issue_pkg::PIPE_ANY, issue_pkg::PIPE_BRANCH}: begin
        pair_conflict = 1'b0;
        swap          = 1'b1;
      end
      default: begin // older already sits in lane 0.
        pair_conflict = 1'b0;
        swap          = 1'b0;
      end
    endcase
  end

endmodule

// File: verilog/hazard_check.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module hazard_check (
  input  issue_pkg::decoded_t      dec0,
  input  issue_pkg::decoded_t      dec1,
  input  issue_pkg::pending_load_t pending_load,
  output logic                     load_block,
  output logic                     raw_block
);

  logic load_hit0;
  logic load_hit1;

  // true when a used source of d names register r.
  function automatic logic reads_reg(
    input issue_pkg::decoded_t       d,
    input logic [`NUM_REGS_LOG2-1:0] r
  );
    return (d.use_src0 && d.src0 == r) || (d.use_src1 && d.src1 == r);
  endfunction

  assign load_hit0 = pending_load.valid && reads_reg(dec0, pending_load.dest);
  assign load_hit1 = pending_load.valid && reads_reg(dec1, pending_load.dest);

  // either slot waiting on the load holds the whole pair.
  assign load_block = load_hit0 || load_hit1;

  // younger slot reads what the older one writes.
  assign raw_block = dec0.use_dest && reads_reg(dec1, dec0.dest);

endmodule

// File: verilog/inst_decode.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module inst_decode (
  input  logic [`INST_WIDTH-1:0] instruction,
  output issue_pkg::decoded_t    dec
);

  logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
  logic [`NUM_REGS_LOG2-1:0]        rs;
  logic [`NUM_REGS_LOG2-1:0]        rt;
  logic [`NUM_REGS_LOG2-1:0]        rd;

  assign opcode = instruction[`OPCODE_MSB:`OPCODE_LSB];
  assign rs     = instruction[`RS_MSB:`RS_LSB];
  assign rt     = instruction[`RT_MSB:`RT_LSB];
  assign rd     = instruction[`RD_MSB:`RD_LSB];

  always_comb begin
    dec = '0;

    // register usage.
    casez (opcode)
      `OP_NOP: begin
      end
      `OP_JR: begin
        dec.src0     = rs;
        dec.use_src0 = 1'b1;
      end
      6'b00????: begin // alu reg-reg.
        dec.src0     = rs;
        dec.src1     = rt;
        dec.dest     = rd;
        dec.use_src0 = 1'b1;
        dec.use_src1 = 1'b1;
        dec.use_dest = 1'b1;
      end
      6'b01????: begin // alu immediate.
        dec.src0     = rs;
        dec.dest     = rt;
        dec.use_src0 = 1'b1;
        dec.use_dest = 1'b1;
      end
      6'b10????: begin
        if (opcode == `OP_LW) begin
          dec.src0     = rs;
          dec.dest     = rt;
          dec.use_src0 = 1'b1;
          dec.use_dest = 1'b1;
        end else if (opcode == `OP_SW) begin
          dec.src0     = rs;
          dec.src1     = rt;
          dec.use_src0 = 1'b1;
          dec.use_src1 = 1'b1;
        end
      end
      default: begin // jumps read nothing.
      end
    endcase

    // lane class.
    casez (opcode)
      `OP_CMP, `OP_TEST, `OP_CMPI, `OP_TESTI: dec.pipe = issue_pkg::PIPE_BRANCH;
      6'b10????: dec.pipe = issue_pkg::PIPE_MEMORY;
      6'b11????: dec.pipe = issue_pkg::PIPE_BRANCH;
      default:   dec.pipe = issue_pkg::PIPE_ANY;
    endcase
  end

endmodule

// File: verilog/issue_queue.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module issue_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = `QUEUE_DEPTH
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  logic     push0,
  input  logic     push1,
  input  payload_t push_data0,
  input  payload_t push_data1,
  input  logic [1:0] pop_count,
  output payload_t head0,
  output payload_t head1,
  output logic [1:0] head_valid,
  output logic [3:0] free
);

  localparam int ptr_w = $clog2(depth);

  payload_t         mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr1;
  logic [ptr_w-1:0] wr_ptr1;
  logic [3:0]       count;
  logic [1:0]       push_n;

  assign push_n  = {1'b0, push0} + {1'b0, push1};
  assign rd_ptr1 = rd_ptr + ptr_w'(1);
  assign wr_ptr1 = wr_ptr + ptr_w'(1);

  //////////////////////////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push0) begin
      mem[wr_ptr] <= push_data0; // older entry.
    end
    if (push1) begin
      mem[wr_ptr1] <= push_data1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0; // same-cycle pushes are dropped too.
    end else begin
      rd_ptr <= rd_ptr + ptr_w'(pop_count);
      wr_ptr <= wr_ptr + ptr_w'(push_n);
      count  <= count + 4'(push_n) - 4'(pop_count);
    end
  end

  assign head_valid = {count > 4'd1, count != 4'd0};
  // empty slots read as zero, so they decode as nop.
  assign head0 = head_valid[0] ? mem[rd_ptr] : '0;
  assign head1 = head_valid[1] ? mem[rd_ptr1] : '0;
  assign free  = 4'(depth) - count;

  //////////////////////////////////////////////////////////////////////
  // protocol checks
  //////////////////////////////////////////////////////////////////////

  a_push_room: assert property (@(posedge clk) disable iff (reset)
    4'(push_n) <= free)
    else $error("push of %0d entries with only %0d free", push_n, free);

  a_pop_occupancy: assert property (@(posedge clk) disable iff (reset)
    4'(pop_count) <= count)
    else $error("pop of %0d entries with only %0d held", pop_count, count);

  a_push_order: assert property (@(posedge clk) disable iff (reset)
    push1 |-> push0)
    else $error("push1 without push0");

endmodule

// File: verilog/issue_pkg.sv
`include "issue_config.svh"

package issue_pkg;

  // which special lane an instruction needs.
  typedef enum logic [1:0] {
    PIPE_ANY    = 2'd0,
    PIPE_BRANCH = 2'd1,
    PIPE_MEMORY = 2'd2
  } pipe_class_e;

  // one queue entry, prediction fields ride along untouched.
  typedef struct packed {
    logic [`INST_WIDTH-1:0] instruction;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ID_WIDTH-1:0]   id;
    logic                   branch_taken;
    logic [`ADDR_WIDTH-1:0] branch_target;
  } issue_entry_t;

  typedef struct packed {
    logic [`NUM_REGS_LOG2-1:0] src0;
    logic [`NUM_REGS_LOG2-1:0] src1;
    logic [`NUM_REGS_LOG2-1:0] dest;
    logic                      use_src0;
    logic                      use_src1;
    logic                      use_dest;
    pipe_class_e               pipe;
  } decoded_t;

  typedef struct packed {
    logic         valid;
    issue_entry_t entry;
  } lane_t;

  // load still in flight.
  typedef struct packed {
    logic                      valid;
    logic [`NUM_REGS_LOG2-1:0] dest;
  } pending_load_t;

endpackage

// File: include/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// datapath widths.
`define INST_WIDTH     32
`define ADDR_WIDTH     32
`define ID_WIDTH       6
`define NUM_REGS_LOG2  5
`define QUEUE_DEPTH    8

// instruction fields.
`define OPCODE_MSB     31
`define OPCODE_LSB     26
`define RS_MSB         25
`define RS_LSB         21
`define RT_MSB         20
`define RT_LSB         16
`define RD_MSB         15
`define RD_LSB         11

// opcodes the stage looks at.
`define OP_NOP         6'h00
`define OP_CMP         6'h0c
`define OP_TEST        6'h0d
`define OP_JR          6'h0f
`define OP_CMPI        6'h1c
`define OP_TESTI       6'h1d
`define OP_LW          6'h20
`define OP_SW          6'h21

`endif
